//--- Makefile
TOP = tb_gmii_tx_mac

.PHONY: all build run lint clean

all: run

build: obj_dir/V$(TOP)

obj_dir/V$(TOP): list.f *.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f list.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "all tests passed" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f list.f

clean:
	rm -rf obj_dir sim.log

//--- gmii_tx_mac.sv
`timescale 1ns/1ns

module gmii_tx_mac (
    input  logic                     interface_clk,
    input  logic                     rstn_mac,
    // best-effort queue
    input  logic [15:0]              ptr_fifo_din,
    input  logic                     ptr_fifo_empty,
    output logic                     ptr_fifo_rd,
    input  logic [7:0]               data_fifo_din,
    output logic                     data_fifo_rd,
    // tte queue
    input  logic [15:0]              tptr_fifo_din,
    input  logic                     tptr_fifo_empty,
    output logic                     tptr_fifo_rd,
    input  logic [7:0]               tdata_fifo_din,
    output logic                     tdata_fifo_rd,
    // gmii
    output tx_mac_pkg::gmii_tx_t     gmii_tx,
    // management
    output logic                     tx_mgnt_valid,
    output tx_mac_pkg::mgnt_report_t tx_mgnt_data,
    input  logic                     tx_mgnt_resp
);
    import tx_mac_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // internal links
    //////////////////////////////////////////////////////////////////////

    logic       engine_ready;
    logic       req_valid;
    tx_req_t    tx_req;
    logic       byte_req;
    logic [7:0] byte_data;
    logic       frame_start;

    // request accepted by the engine
    assign frame_start = req_valid && engine_ready;

    // queue select, pointer fetch, byte routing
    tx_queue_arbiter u_arbiter (
        .interface_clk   (interface_clk),
        .rstn_mac        (rstn_mac),
        .ptr_fifo_empty  (ptr_fifo_empty),
        .ptr_fifo_din    (ptr_fifo_din),
        .ptr_fifo_rd     (ptr_fifo_rd),
        .data_fifo_din   (data_fifo_din),
        .data_fifo_rd    (data_fifo_rd),
        .tptr_fifo_empty (tptr_fifo_empty),
        .tptr_fifo_din   (tptr_fifo_din),
        .tptr_fifo_rd    (tptr_fifo_rd),
        .tdata_fifo_din  (tdata_fifo_din),
        .tdata_fifo_rd   (tdata_fifo_rd),
        .engine_ready    (engine_ready),
        .byte_req        (byte_req),
        .req_valid       (req_valid),
        .tx_req          (tx_req),
        .byte_data       (byte_data)
    );

    // preamble, payload, fcs, gap
    tx_frame_engine u_engine (
        .interface_clk (interface_clk),
        .rstn_mac      (rstn_mac),
        .req_valid     (req_valid),
        .tx_req        (tx_req),
        .byte_data     (byte_data),
        .engine_ready  (engine_ready),
        .byte_req      (byte_req),
        .gmii_tx       (gmii_tx)
    );

    // per-frame report to management
    tx_mgnt_report u_mgnt (
        .interface_clk (interface_clk),
        .rstn_mac      (rstn_mac),
        .frame_start   (frame_start),
        .tx_req        (tx_req),
        .tx_mgnt_resp  (tx_mgnt_resp),
        .tx_mgnt_valid (tx_mgnt_valid),
        .tx_mgnt_data  (tx_mgnt_data)
    );

endmodule

//--- gmii_tx_mac_assertions.sv
`timescale 1ns/1ns

module gmii_tx_mac_assertions (
    input logic                 interface_clk,
    input logic                 rstn_mac,
    input logic                 ptr_fifo_rd,
    input logic                 ptr_fifo_empty,
    input logic                 tptr_fifo_rd,
    input logic                 tptr_fifo_empty,
    input tx_mac_pkg::gmii_tx_t gmii_tx,
    input logic                 tx_mgnt_valid,
    input logic                 tx_mgnt_resp,
    input logic                 frame_start,
    input tx_mac_pkg::tx_req_t  tx_req
);
    import tx_mac_pkg::*;

    int               dv_cnt;
    logic [LEN_W-1:0] len_q;
    // failing assertions so far
    int               fail_cnt = 0;

    // length of the frame on the wire and cycles of dv so far
    always_ff @(posedge interface_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            dv_cnt <= 0;
            len_q  <= '0;
        end else begin
            dv_cnt <= gmii_tx.dv ? dv_cnt + 1 : 0;
            if (frame_start) begin
                len_q <= tx_req.len;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // pointer fifo reads
    //////////////////////////////////////////////////////////////////////

    a_ptr_pulse: assert property (@(posedge interface_clk) disable iff (!rstn_mac)
        ptr_fifo_rd |=> !ptr_fifo_rd)
        else begin
            fail_cnt++;
            $error("be pointer read longer than one cycle");
        end
    a_tptr_pulse: assert property (@(posedge interface_clk) disable iff (!rstn_mac)
        tptr_fifo_rd |=> !tptr_fifo_rd)
        else begin
            fail_cnt++;
            $error("tte pointer read longer than one cycle");
        end
    a_ptr_empty: assert property (@(posedge interface_clk) disable iff (!rstn_mac)
        $rose(ptr_fifo_rd) |-> $past(!ptr_fifo_empty))
        else begin
            fail_cnt++;
            $error("be pointer read while empty");
        end
    a_tptr_empty: assert property (@(posedge interface_clk) disable iff (!rstn_mac)
        $rose(tptr_fifo_rd) |-> $past(!tptr_fifo_empty))
        else begin
            fail_cnt++;
            $error("tte pointer read while empty");
        end

    // dv only falls once the whole frame is out
    a_dv_whole: assert property (@(posedge interface_clk) disable iff (!rstn_mac)
        $fell(gmii_tx.dv) |-> (dv_cnt == PREAMBLE_LEN + int'(len_q) + CRC_LEN))
        else begin
            fail_cnt++;
            $error("dv dropped inside a frame");
        end

    // report held until management answers
    a_mgnt_hold: assert property (@(posedge interface_clk) disable iff (!rstn_mac)
        (tx_mgnt_valid && !tx_mgnt_resp) |=> tx_mgnt_valid)
        else begin
            fail_cnt++;
            $error("management report dropped before response");
        end

endmodule

bind gmii_tx_mac gmii_tx_mac_assertions u_assertions (
    .interface_clk   (interface_clk),
    .rstn_mac        (rstn_mac),
    .ptr_fifo_rd     (ptr_fifo_rd),
    .ptr_fifo_empty  (ptr_fifo_empty),
    .tptr_fifo_rd    (tptr_fifo_rd),
    .tptr_fifo_empty (tptr_fifo_empty),
    .gmii_tx         (gmii_tx),
    .tx_mgnt_valid   (tx_mgnt_valid),
    .tx_mgnt_resp    (tx_mgnt_resp),
    .frame_start     (frame_start),
    .tx_req          (tx_req)
);

//--- list.f
tx_mac_pkg.sv
tx_crc32.sv
tx_queue_arbiter.sv
tx_frame_engine.sv
tx_mgnt_report.sv
gmii_tx_mac.sv
tb_clock_gen.sv
gmii_tx_mac_assertions.sv
tb_gmii_tx_mac.sv

//--- tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
    output logic interface_clk,
    output logic rstn_mac
);
    // 25 MHz for the testbench, 40 ns period
    initial begin
        interface_clk = 1'b0;
        forever begin
            #20 interface_clk = ~interface_clk;
        end
    end

    // reset held low for 5 clock cycles
    initial begin
        rstn_mac = 1'b0;
        repeat (5) @(posedge interface_clk);
        @(negedge interface_clk);
        rstn_mac = 1'b1;
    end

endmodule

//--- tb_gmii_tx_mac.sv
`timescale 1ns/1ns

module tb_gmii_tx_mac;
    import tx_mac_pkg::*;

    logic         interface_clk;
    logic         rstn_mac;
    logic [15:0]  ptr_fifo_din;
    logic         ptr_fifo_empty;
    logic         ptr_fifo_rd;
    logic [7:0]   data_fifo_din;
    logic         data_fifo_rd;
    logic [15:0]  tptr_fifo_din;
    logic         tptr_fifo_empty;
    logic         tptr_fifo_rd;
    logic [7:0]   tdata_fifo_din;
    logic         tdata_fifo_rd;
    gmii_tx_t     gmii_tx;
    logic         tx_mgnt_valid;
    mgnt_report_t tx_mgnt_data;
    logic         tx_mgnt_resp;

    integer seed = 79232;
    int     err_cnt = 0;
    int     chk_cnt = 0;
    int     b2b_len[6];

    // fifo model storage with one pair per queue
    logic [15:0] be_ptr_q[$];
    logic [15:0] tte_ptr_q[$];
    logic [7:0]  be_data_q[$];
    logic [7:0]  tte_data_q[$];
    logic [15:0] be_ptr_hold;
    logic [15:0] tte_ptr_hold;
    logic [7:0]  be_data_hold;
    logic [7:0]  tte_data_hold;
    logic        be_ptr_pend = 1'b0;
    logic        tte_ptr_pend = 1'b0;
    logic        be_data_pend = 1'b0;
    logic        tte_data_pend = 1'b0;

    // gmii monitor state
    logic [7:0] rx_bytes[$];
    int         rx_lens[$];
    int         rx_delay[$];
    int         cyc = 0;
    int         rd_cycle = 0;
    int         cur_len = 0;
    int         idle_cnt = 0;
    int         min_gap = 1000;
    int         frames_seen = 0;
    logic       dv_prev = 1'b0;

    tb_clock_gen u_clk (
        .interface_clk (interface_clk),
        .rstn_mac      (rstn_mac)
    );

    gmii_tx_mac u_dut (
        .interface_clk   (interface_clk),
        .rstn_mac        (rstn_mac),
        .ptr_fifo_din    (ptr_fifo_din),
        .ptr_fifo_empty  (ptr_fifo_empty),
        .ptr_fifo_rd     (ptr_fifo_rd),
        .data_fifo_din   (data_fifo_din),
        .data_fifo_rd    (data_fifo_rd),
        .tptr_fifo_din   (tptr_fifo_din),
        .tptr_fifo_empty (tptr_fifo_empty),
        .tptr_fifo_rd    (tptr_fifo_rd),
        .tdata_fifo_din  (tdata_fifo_din),
        .tdata_fifo_rd   (tdata_fifo_rd),
        .gmii_tx         (gmii_tx),
        .tx_mgnt_valid   (tx_mgnt_valid),
        .tx_mgnt_data    (tx_mgnt_data),
        .tx_mgnt_resp    (tx_mgnt_resp)
    );

    //////////////////////////////////////////////////////////////////////
    // fifo models answering reads one cycle later
    //////////////////////////////////////////////////////////////////////

    always @(negedge interface_clk) begin
        // word popped last edge goes out now
        if (be_ptr_pend) ptr_fifo_din = be_ptr_hold;
        if (tte_ptr_pend) tptr_fifo_din = tte_ptr_hold;
        if (be_data_pend) data_fifo_din = be_data_hold;
        if (tte_data_pend) tdata_fifo_din = tte_data_hold;
        be_ptr_pend   = ptr_fifo_rd && (be_ptr_q.size() > 0);
        tte_ptr_pend  = tptr_fifo_rd && (tte_ptr_q.size() > 0);
        be_data_pend  = data_fifo_rd && (be_data_q.size() > 0);
        tte_data_pend = tdata_fifo_rd && (tte_data_q.size() > 0);
        if (be_ptr_pend) be_ptr_hold = be_ptr_q.pop_front();
        if (tte_ptr_pend) tte_ptr_hold = tte_ptr_q.pop_front();
        if (be_data_pend) be_data_hold = be_data_q.pop_front();
        if (tte_data_pend) tte_data_hold = tte_data_q.pop_front();
        ptr_fifo_empty  = (be_ptr_q.size() == 0);
        tptr_fifo_empty = (tte_ptr_q.size() == 0);
    end

    // frame collector sampling gmii on the falling edge
    always @(negedge interface_clk) begin
        cyc = cyc + 1;
        if (ptr_fifo_rd || tptr_fifo_rd) rd_cycle = cyc;
        if (gmii_tx.dv) begin
            if (!dv_prev) begin
                rx_delay.push_back(cyc - rd_cycle);
                if (frames_seen > 0 && idle_cnt < min_gap) min_gap = idle_cnt;
            end
            rx_bytes.push_back(gmii_tx.d);
            cur_len  = cur_len + 1;
            idle_cnt = 0;
        end else begin
            if (dv_prev) begin
                rx_lens.push_back(cur_len);
                cur_len     = 0;
                frames_seen = frames_seen + 1;
            end
            idle_cnt = idle_cnt + 1;
        end
        dv_prev = gmii_tx.dv;
    end

    //////////////////////////////////////////////////////////////////////
    // compare tasks and reference
    //////////////////////////////////////////////////////////////////////

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("FAILED %0t ns: %s got %02h expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_report(input mgnt_report_t got, input mgnt_report_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("FAILED %0t ns: report got %04h expected %04h", $time, got, exp);
        end
    endtask

    // at_least set for gaps and exact match otherwise
    task automatic check_count(input int got, input int exp, input string what,
                               input bit at_least);
        chk_cnt++;
        if (at_least ? (got < exp) : (got != exp)) begin
            err_cnt++;
            $display("FAILED %0t ns: %s got %0d expected %s%0d", $time, what, got,
                     at_least ? ">= " : "", exp);
        end
    endtask

    // reflected 802.3 fcs inverted at the end
    function automatic logic [31:0] crc_ref(input logic [7:0] pl[$]);
        logic [31:0] c;
        c = 32'hFFFF_FFFF;
        foreach (pl[i]) begin
            c = c ^ {24'h0, pl[i]};
            for (int b = 0; b < 8; b++) begin
                c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
            end
        end
        return ~c;
    endfunction

    // data goes in before its pointer
    // upper pointer bits are random
    task automatic load_frame(input queue_e q, input int len, output logic [7:0] pl[$]);
        logic [15:0] ptr;
        pl = {};
        for (int i = 0; i < len; i++) begin
            pl.push_back(8'($random(seed)));
        end
        ptr = {4'($random(seed)), 12'(len)};
        if (q == QUEUE_TTE) begin
            foreach (pl[i]) tte_data_q.push_back(pl[i]);
            tte_ptr_q.push_back(ptr);
        end else begin
            foreach (pl[i]) be_data_q.push_back(pl[i]);
            be_ptr_q.push_back(ptr);
        end
    endtask

    // takes the next collected frame
    // delay -1 skips the latency check
    task automatic compare_frame(input logic [7:0] pl[$], input int exp_delay);
        logic [7:0]  exp[$];
        logic [31:0] crc;
        int          n;
        int          d;
        while (rx_lens.size() == 0) @(negedge interface_clk);
        n   = rx_lens.pop_front();
        d   = rx_delay.pop_front();
        crc = crc_ref(pl);
        for (int i = 0; i < 7; i++) exp.push_back(8'h55);
        exp.push_back(8'hD5);
        foreach (pl[i]) exp.push_back(pl[i]);
        for (int i = 0; i < 4; i++) exp.push_back(crc[8*i +: 8]);
        check_count(n, exp.size(), "frame length", 1'b0);
        for (int i = 0; i < n; i++) begin
            if (rx_bytes.size() == 0) break;
            if (i < exp.size()) check_byte(rx_bytes.pop_front(), exp[i], "frame byte");
            else void'(rx_bytes.pop_front());
        end
        if (exp_delay >= 0) check_count(d, exp_delay, "pointer read to dv", 1'b0);
    endtask

    task automatic wait_report();
        while (!tx_mgnt_valid) @(negedge interface_clk);
    endtask

    task automatic ack_report();
        if (tx_mgnt_valid) begin
            tx_mgnt_resp = 1'b1;
            @(negedge interface_clk);
            tx_mgnt_resp = 1'b0;
            @(negedge interface_clk);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic reset_outputs_low();
        for (int i = 0; i < 8; i++) begin
            @(negedge interface_clk);
            check_count(int'({ptr_fifo_rd, tptr_fifo_rd} !== 2'b00), 0,
                        "pointer read in reset", 1'b0);
            check_count(int'({data_fifo_rd, tdata_fifo_rd} !== 2'b00), 0,
                        "data read in reset", 1'b0);
            check_count(int'(gmii_tx.dv !== 1'b0), 0, "dv in reset", 1'b0);
            check_count(int'(tx_mgnt_valid !== 1'b0), 0, "mgnt valid in reset", 1'b0);
        end
    endtask

    task automatic single_be_frame();
        logic [7:0] pl[$];
        load_frame(QUEUE_BE, 20, pl);
        compare_frame(pl, 3);
        wait_report();
        check_report(tx_mgnt_data, '{tte: 1'b0, rsvd: 3'b000, len: 12'd20});
        ack_report();
    endtask

    task automatic tte_first();
        logic [7:0] be_pl[$];
        logic [7:0] tte_pl[$];
        load_frame(QUEUE_BE, 40, be_pl);
        load_frame(QUEUE_TTE, 25, tte_pl);
        compare_frame(tte_pl, -1);
        compare_frame(be_pl, -1);
        // second report dropped while the first is held
        check_report(tx_mgnt_data, '{tte: 1'b1, rsvd: 3'b000, len: 12'd25});
        ack_report();
    endtask

    task automatic back_to_back_frames();
        logic [7:0] pl[6][$];
        min_gap = 1000;
        for (int i = 0; i < 6; i++) load_frame(QUEUE_BE, b2b_len[i], pl[i]);
        for (int i = 0; i < 6; i++) compare_frame(pl[i], -1);
        check_count(min_gap, 12, "inter-frame gap", 1'b1);
        ack_report();
    endtask

    task automatic mgnt_handshake();
        logic [7:0] pl_a[$];
        logic [7:0] pl_b[$];
        load_frame(QUEUE_TTE, 30, pl_a);
        wait_report();
        check_report(tx_mgnt_data, '{tte: 1'b1, rsvd: 3'b000, len: 12'd30});
        compare_frame(pl_a, -1);
        // second frame starts with the report still open
        load_frame(QUEUE_BE, 10, pl_b);
        compare_frame(pl_b, -1);
        check_count(int'(tx_mgnt_valid), 1, "mgnt valid held", 1'b0);
        check_report(tx_mgnt_data, '{tte: 1'b1, rsvd: 3'b000, len: 12'd30});
        tx_mgnt_resp = 1'b1;
        @(negedge interface_clk);
        tx_mgnt_resp = 1'b0;
        for (int i = 0; i < 5; i++) begin
            check_count(int'(tx_mgnt_valid), 0, "mgnt valid after response", 1'b0);
            @(negedge interface_clk);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        longint limit_ns;
        int     bytes;
        ptr_fifo_din    = '0;
        tptr_fifo_din   = '0;
        data_fifo_din   = '0;
        tdata_fifo_din  = '0;
        ptr_fifo_empty  = 1'b1;
        tptr_fifo_empty = 1'b1;
        tx_mgnt_resp    = 1'b0;
        foreach (b2b_len[i]) b2b_len[i] = 1 + int'({$random(seed)} % 200);
        // len + 25 cycles for every frame of every test
        bytes = (20 + 25) + (40 + 25) + (25 + 25) + (30 + 25) + (10 + 25);
        foreach (b2b_len[i]) bytes = bytes + b2b_len[i] + 25;
        limit_ns = 2 * longint'(bytes) * 40 + 2000;
        fork
            begin
                #(limit_ns);
                $display("watchdog expired after %0d ns, DUT stopped sending frames", limit_ns);
                $display("tests failed");
                $finish;
            end
        join_none
        reset_outputs_low();
        single_be_frame();
        tte_first();
        back_to_back_frames();
        mgnt_handshake();
        $display("checks %0d, errors %0d, assertion failures %0d", chk_cnt, err_cnt,
                 u_dut.u_assertions.fail_cnt);
        if (err_cnt == 0 && u_dut.u_assertions.fail_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- tx_crc32.sv
`timescale 1ns/1ns

module tx_crc32 (
    input  logic        interface_clk,
    input  logic        rstn_mac,
    input  logic        crc_init,
    input  logic        crc_en,
    input  logic [7:0]  crc_byte,
    output logic [31:0] crc_value
);
    import tx_mac_pkg::*;

    logic [31:0] crc_q;
    logic [31:0] crc_next;

    //////////////////////////////////////////////////////////////////////
    // byte step, eight serial shifts unrolled
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        // byte enters lsb first
        crc_next = crc_q ^ {24'h00_0000, crc_byte};
        for (int i = 0; i < 8; i++) begin
            // feedback taps when the bit shifted out is set
            if (crc_next[0]) begin
                crc_next = (crc_next >> 1) ^ CRC_POLY;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    // running remainder
    always_ff @(posedge interface_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            crc_q <= CRC_INIT;
        end else if (crc_init) begin
            // reload for the next frame
            crc_q <= CRC_INIT;
        end else if (crc_en) begin
            crc_q <= crc_next;
        end
    end

    // fcs is the inverted remainder
    // valid the cycle after the last byte
    assign crc_value = ~crc_q;

endmodule

//--- tx_frame_engine.sv
`timescale 1ns/1ns

module tx_frame_engine (
    input  logic                 interface_clk,
    input  logic                 rstn_mac,
    input  logic                 req_valid,
    input  tx_mac_pkg::tx_req_t  tx_req,
    input  logic [7:0]           byte_data,
    output logic                 engine_ready,
    output logic                 byte_req,
    output tx_mac_pkg::gmii_tx_t gmii_tx
);
    import tx_mac_pkg::*;

    frame_state_e     state;
    logic [2:0]       pre_cnt;
    logic [LEN_W-1:0] data_cnt;
    logic [LEN_W-1:0] len_q;
    logic [1:0]       crc_cnt;
    logic [3:0]       gap_cnt;
    logic             accept;
    logic             last_byte;
    logic             last_pre;
    logic [31:0]      crc_value;
    gmii_tx_t         tx_next;

    // only idle takes a new frame
    assign engine_ready = (state == ST_IDLE);
    assign accept       = req_valid && engine_ready;

    assign last_pre  = (pre_cnt == 3'(PREAMBLE_LEN - 1));
    assign last_byte = (data_cnt == len_q - 1'b1);

    // byte strobes lead the output by two cycles
    // first one goes out with the sfd load
    assign byte_req = ((state == ST_PREAMBLE) && last_pre) ||
                      ((state == ST_DATA) && !last_byte);

    // payload length for this frame
    always_ff @(posedge interface_clk) begin
        if (accept) begin
            len_q <= tx_req.len;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // frame fsm and counters
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge interface_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            state    <= ST_IDLE;
            pre_cnt  <= '0;
            data_cnt <= '0;
            crc_cnt  <= '0;
            gap_cnt  <= '0;
        end else begin
            unique case (state)
                ST_IDLE: begin
                    // first preamble byte is loaded on accept
                    if (accept) begin
                        state   <= ST_PREAMBLE;
                        pre_cnt <= 3'd1;
                    end
                end
                ST_PREAMBLE: begin
                    pre_cnt <= pre_cnt + 1'b1;
                    if (last_pre) begin
                        state    <= ST_DATA;
                        data_cnt <= '0;
                    end
                end
                ST_DATA: begin
                    data_cnt <= data_cnt + 1'b1;
                    // fcs follows with no gap
                    if (last_byte) begin
                        state   <= ST_CRC;
                        crc_cnt <= '0;
                    end
                end
                ST_CRC: begin
                    crc_cnt <= crc_cnt + 1'b1;
                    if (crc_cnt == 2'(CRC_LEN - 1)) begin
                        state   <= ST_GAP;
                        gap_cnt <= '0;
                    end
                end
                default: begin
                    // ifg, dv held low
                    gap_cnt <= gap_cnt + 1'b1;
                    if (gap_cnt == 4'(IFG_LEN - 1)) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output byte select and gmii register
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        tx_next = '0;
        unique case (state)
            ST_IDLE: begin
                tx_next.dv = accept;
                tx_next.d  = accept ? PREAMBLE_BYTE : 8'h00;
            end
            ST_PREAMBLE: begin
                tx_next.dv = 1'b1;
                tx_next.d  = last_pre ? SFD_BYTE : PREAMBLE_BYTE;
            end
            ST_DATA: begin
                tx_next.dv = 1'b1;
                tx_next.d  = byte_data;
            end
            ST_CRC: begin
                // fcs lsb first
                tx_next.dv = 1'b1;
                tx_next.d  = crc_value[{crc_cnt, 3'b000} +: 8];
            end
            default: begin
                tx_next = '0;
            end
        endcase
    end

    always_ff @(posedge interface_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            gmii_tx <= '0;
        end else begin
            gmii_tx <= tx_next;
        end
    end

    // fcs runs over payload only
    tx_crc32 u_crc32 (
        .interface_clk (interface_clk),
        .rstn_mac      (rstn_mac),
        .crc_init      (accept),
        .crc_en        (state == ST_DATA),
        .crc_byte      (byte_data),
        .crc_value     (crc_value)
    );

endmodule

//--- tx_mac_pkg.sv
package tx_mac_pkg;

    //////////////////////////////////////////////////////////////////////
    // frame constants
    //////////////////////////////////////////////////////////////////////

    // payload length field, bits 11:0 of a pointer word
    localparam int LEN_W = 12;

    // 7 preamble bytes, then the start-of-frame delimiter
    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] SFD_BYTE      = 8'hD5;

    // preamble plus sfd
    localparam int PREAMBLE_LEN = 8;
    // fcs bytes after payload
    localparam int CRC_LEN = 4;
    // minimum inter-frame gap in idle cycles
    localparam int IFG_LEN = 12;

    // 802.3 crc-32, lsb first form
    localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;
    localparam logic [31:0] CRC_POLY = 32'hEDB8_8320;

    //////////////////////////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////////////////////////

    // queue select, tte has strict priority
    typedef enum logic {
        QUEUE_BE  = 1'b0,
        QUEUE_TTE = 1'b1
    } queue_e;

    // one frame request from the arbiter
    typedef struct packed {
        queue_e             queue;
        logic [LEN_W-1:0]   len;
    } tx_req_t;

    // gmii transmit pins
    typedef struct packed {
        logic       dv;
        logic [7:0] d;
    } gmii_tx_t;

    // per-frame report word for management
    typedef struct packed {
        logic               tte;
        logic [2:0]         rsvd;
        logic [LEN_W-1:0]   len;
    } mgnt_report_t;

    // frame engine states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_DATA,
        ST_CRC,
        ST_GAP
    } frame_state_e;

endpackage

//--- tx_mgnt_report.sv
`timescale 1ns/1ns

module tx_mgnt_report (
    input  logic                     interface_clk,
    input  logic                     rstn_mac,
    input  logic                     frame_start,
    input  tx_mac_pkg::tx_req_t      tx_req,
    input  logic                     tx_mgnt_resp,
    output logic                     tx_mgnt_valid,
    output tx_mac_pkg::mgnt_report_t tx_mgnt_data
);
    import tx_mac_pkg::*;

    logic capture;

    // only a free report slot takes a new frame
    // anything else is dropped, tx never stalls
    assign capture = frame_start && !tx_mgnt_valid;

    // valid held until management answers
    always_ff @(posedge interface_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            tx_mgnt_valid <= 1'b0;
        end else if (tx_mgnt_valid) begin
            if (tx_mgnt_resp) begin
                tx_mgnt_valid <= 1'b0;
            end
        end else if (frame_start) begin
            tx_mgnt_valid <= 1'b1;
        end
    end

    // report word, queue flag plus length
    always_ff @(posedge interface_clk) begin
        if (capture) begin
            tx_mgnt_data <= '{
                tte:  (tx_req.queue == QUEUE_TTE),
                rsvd: 3'b000,
                len:  tx_req.len
            };
        end
    end

endmodule

//--- tx_queue_arbiter.sv
`timescale 1ns/1ns

module tx_queue_arbiter (
    input  logic                interface_clk,
    input  logic                rstn_mac,
    // best-effort queue
    input  logic                ptr_fifo_empty,
    input  logic [15:0]         ptr_fifo_din,
    output logic                ptr_fifo_rd,
    input  logic [7:0]          data_fifo_din,
    output logic                data_fifo_rd,
    // tte queue
    input  logic                tptr_fifo_empty,
    input  logic [15:0]         tptr_fifo_din,
    output logic                tptr_fifo_rd,
    input  logic [7:0]          tdata_fifo_din,
    output logic                tdata_fifo_rd,
    // frame engine side
    input  logic                engine_ready,
    input  logic                byte_req,
    output logic                req_valid,
    output tx_mac_pkg::tx_req_t tx_req,
    output logic [7:0]          byte_data
);
    import tx_mac_pkg::*;

    queue_e sel_q;
    logic   fetch;
    logic   busy;
    logic   start;
    logic   pick_tte;

    // strict priority, tte whenever it has a frame
    assign pick_tte = !tptr_fifo_empty;

    // read pulse, data cycle or request still open
    assign busy  = ptr_fifo_rd || tptr_fifo_rd || fetch || req_valid;
    assign start = engine_ready && !busy && (!ptr_fifo_empty || !tptr_fifo_empty);

    //////////////////////////////////////////////////////////////////////
    // pointer read and request handshake
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge interface_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            ptr_fifo_rd  <= 1'b0;
            tptr_fifo_rd <= 1'b0;
            fetch        <= 1'b0;
            req_valid    <= 1'b0;
            sel_q        <= QUEUE_BE;
        end else begin
            // single-cycle pulse on the chosen pointer fifo
            ptr_fifo_rd  <= start && !pick_tte;
            tptr_fifo_rd <= start && pick_tte;
            // pointer word shows up one cycle after the pulse
            fetch        <= ptr_fifo_rd || tptr_fifo_rd;
            // request stays up until the engine takes it
            req_valid    <= fetch || (req_valid && !engine_ready);
            // queue choice held for the whole frame
            if (start) begin
                sel_q <= pick_tte ? QUEUE_TTE : QUEUE_BE;
            end
        end
    end

    // length capture, upper pointer bits ignored
    always_ff @(posedge interface_clk) begin
        if (fetch) begin
            tx_req.queue <= sel_q;
            tx_req.len   <= (sel_q == QUEUE_TTE) ? tptr_fifo_din[LEN_W-1:0]
                                                 : ptr_fifo_din[LEN_W-1:0];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // data byte routing
    //////////////////////////////////////////////////////////////////////

    // byte strobe goes straight to the selected data fifo
    assign data_fifo_rd  = byte_req && (sel_q == QUEUE_BE);
    assign tdata_fifo_rd = byte_req && (sel_q == QUEUE_TTE);

    // fifo answers next cycle, mux on the same choice
    assign byte_data = (sel_q == QUEUE_TTE) ? tdata_fifo_din : data_fifo_din;

endmodule
